/* list.f */
xbar_pkg.sv
xbar_req_if.sv
xbar_egress_if.sv
ingress_slots.sv
rr_pointer.sv
crossbar_fsm.sv
egress_stage.sv
spine_crossbar.sv
tb_clock.sv
tb_spine_crossbar.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the crossbar testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/10ps --top-module tb_spine_crossbar \
    -f list.f -o tb_spine_crossbar
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_spine_crossbar > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

/* tb_spine_crossbar.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_spine_crossbar;

    localparam int NUM_TESTS = 6;
    localparam int CLK_NS    = 20;

    logic            clk;
    logic            reset;
    logic            arb_enable;
    xbar_pkg::data_t gpu_in_data;
    logic            gpu_in_valid;
    logic            gpu_in_ready;
    xbar_pkg::addr_t gpu_dest_addr;
    xbar_pkg::data_t gpu_out_data;
    logic            gpu_out_valid;
    logic            gpu_out_ready;
    logic            busy;
    xbar_pkg::port_e current_grant;
    xbar_pkg::dir_e  direction;

    // Indexed by spine number
    xbar_pkg::data_t spine_out_data  [1:4];
    logic            spine_out_valid [1:4];
    logic            spine_out_ready [1:4];
    xbar_pkg::data_t spine_in_data   [1:4];
    logic            spine_in_valid  [1:4];
    logic            spine_in_ready  [1:4];

    // Output words in arrival order
    xbar_pkg::port_e log_port  [$];
    xbar_pkg::data_t log_data  [$];
    xbar_pkg::port_e log_grant [$];
    xbar_pkg::dir_e  log_dir   [$];

    logic [31:0]     rng_state = 32'd41;
    xbar_pkg::data_t src_word  [0:4];
    xbar_pkg::port_e gpu_dst;

    tb_clock u_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    spine_crossbar u_spine_crossbar (
        .*,
        .spine1_out_data  (spine_out_data[1]),
        .spine1_out_valid (spine_out_valid[1]),
        .spine1_out_ready (spine_out_ready[1]),
        .spine1_in_data   (spine_in_data[1]),
        .spine1_in_valid  (spine_in_valid[1]),
        .spine1_in_ready  (spine_in_ready[1]),
        .spine2_out_data  (spine_out_data[2]),
        .spine2_out_valid (spine_out_valid[2]),
        .spine2_out_ready (spine_out_ready[2]),
        .spine2_in_data   (spine_in_data[2]),
        .spine2_in_valid  (spine_in_valid[2]),
        .spine2_in_ready  (spine_in_ready[2]),
        .spine3_out_data  (spine_out_data[3]),
        .spine3_out_valid (spine_out_valid[3]),
        .spine3_out_ready (spine_out_ready[3]),
        .spine3_in_data   (spine_in_data[3]),
        .spine3_in_valid  (spine_in_valid[3]),
        .spine3_in_ready  (spine_in_ready[3]),
        .spine4_out_data  (spine_out_data[4]),
        .spine4_out_valid (spine_out_valid[4]),
        .spine4_out_ready (spine_out_ready[4]),
        .spine4_in_data   (spine_in_data[4]),
        .spine4_in_valid  (spine_in_valid[4]),
        .spine4_in_ready  (spine_in_ready[4])
    );

    // ====================
    // Collector
    // ====================
    function automatic void record(input xbar_pkg::port_e port, input xbar_pkg::data_t data);
        log_port.push_back(port);
        log_data.push_back(data);
        log_grant.push_back(current_grant);
        log_dir.push_back(direction);
    endfunction

    // Valid and ready seen here means a transfer on the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (gpu_out_valid && gpu_out_ready) begin
                record(xbar_pkg::PORT_GPU, gpu_out_data);
            end
            for (int i = 1; i <= 4; i++) begin
                if (spine_in_valid[i] && spine_in_ready[i]) begin
                    record(xbar_pkg::port_e'(3'(i + 1)), spine_in_data[i]);
                end
            end
        end
    end

    function automatic void clear_log();
        log_port.delete();
        log_data.delete();
        log_grant.delete();
        log_dir.delete();
    endfunction

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic xbar_pkg::data_t next_word();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic put_gpu(input xbar_pkg::data_t data, input xbar_pkg::addr_t addr);
        @(posedge clk);
        gpu_in_data   <= data;
        gpu_dest_addr <= addr;
        gpu_in_valid  <= 1'b1;
        do @(negedge clk); while (!gpu_in_ready);
        @(posedge clk);
        gpu_in_valid <= 1'b0;
    endtask

    task automatic put_spine(input int n, input xbar_pkg::data_t data);
        @(posedge clk);
        spine_out_data[n]  <= data;
        spine_out_valid[n] <= 1'b1;
        do @(negedge clk); while (!spine_out_ready[n]);
        @(posedge clk);
        spine_out_valid[n] <= 1'b0;
    endtask

    // All five sources on one edge
    task automatic load_all(input xbar_pkg::addr_t addr);
        @(posedge clk);
        gpu_in_data   <= src_word[0];
        gpu_dest_addr <= addr;
        gpu_in_valid  <= 1'b1;
        for (int i = 1; i <= 4; i++) begin
            spine_out_data[i]  <= src_word[i];
            spine_out_valid[i] <= 1'b1;
        end
        @(negedge clk);
        compare("gpu_in_ready at burst", 32'd1, 32'(gpu_in_ready));
        for (int i = 1; i <= 4; i++) begin
            compare($sformatf("spine%0d_out_ready at burst", i), 32'd1,
                    32'(spine_out_ready[i]));
        end
        @(posedge clk);
        gpu_in_valid <= 1'b0;
        for (int i = 1; i <= 4; i++) begin
            spine_out_valid[i] <= 1'b0;
        end
    endtask

    task automatic wait_done(input int n);
        while (log_data.size() < n) @(posedge clk);
        do @(negedge clk); while (busy);
        compare("word count", 32'(n), 32'(log_data.size()));
    endtask

    task automatic verify_word(input int k, input xbar_pkg::port_e port,
                               input xbar_pkg::data_t data, input xbar_pkg::port_e grant,
                               input xbar_pkg::dir_e dir);
        compare($sformatf("word %0d port", k), 32'(port), 32'(log_port[k]));
        compare($sformatf("word %0d data", k), 32'(data), 32'(log_data[k]));
        compare($sformatf("word %0d current_grant", k), 32'(grant), 32'(log_grant[k]));
        compare($sformatf("word %0d direction", k), 32'(dir), 32'(log_dir[k]));
    endtask

    // Slot 0 is the GPU and slots 1 to 4 are the spines
    task automatic verify_burst(input logic arb);
        int fixed_order [0:4];
        int rr_order    [0:4];
        int slot;
        fixed_order = '{0, 1, 2, 3, 4};
        // Pointer sits at slot 1 when the burst starts
        rr_order    = '{1, 2, 3, 4, 0};
        for (int k = 0; k < 5; k++) begin
            slot = arb ? rr_order[k] : fixed_order[k];
            verify_word(k, (slot == 0) ? gpu_dst : xbar_pkg::PORT_GPU, src_word[slot],
                        xbar_pkg::port_e'(3'(slot + 1)),
                        (slot == 0) ? xbar_pkg::DIR_DOWN : xbar_pkg::DIR_UP);
        end
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic reset_values();
        @(negedge clk);
        compare("gpu_out_valid after reset", 32'd0, 32'(gpu_out_valid));
        compare("gpu_in_ready after reset", 32'd1, 32'(gpu_in_ready));
        for (int i = 1; i <= 4; i++) begin
            compare($sformatf("spine%0d_in_valid after reset", i), 32'd0,
                    32'(spine_in_valid[i]));
            compare($sformatf("spine%0d_out_ready after reset", i), 32'd1,
                    32'(spine_out_ready[i]));
        end
        compare("busy after reset", 32'd0, 32'(busy));
        compare("current_grant after reset", 32'(xbar_pkg::PORT_NONE), 32'(current_grant));
        compare("direction after reset", 32'(xbar_pkg::DIR_NONE), 32'(direction));
    endtask

    task automatic route_gpu_words();
        logic [3:0]      fields [0:5];
        int              spine  [0:5];
        xbar_pkg::data_t word;
        xbar_pkg::data_t lo;
        // Select field and the spine it should reach
        fields = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd0, 4'd9};
        spine  = '{1, 2, 3, 4, 1, 1};
        for (int n = 0; n < 6; n++) begin
            clear_log();
            word = next_word();
            lo   = next_word();
            put_gpu(word, {fields[n], lo[1:0]});
            wait_done(1);
            verify_word(0, xbar_pkg::port_e'(3'(spine[n] + 1)), word,
                        xbar_pkg::PORT_GPU, xbar_pkg::DIR_DOWN);
        end
    endtask

    task automatic return_spine_words();
        xbar_pkg::data_t word;
        int              lat;
        for (int n = 1; n <= 4; n++) begin
            clear_log();
            word = next_word();
            put_spine(n, word);
            if (n == 1) begin
                lat = 0;
                @(negedge clk);
                while (!gpu_out_valid) begin
                    lat++;
                    @(negedge clk);
                end
                compare("spine to GPU latency", 32'd3, 32'(lat));
            end
            wait_done(1);
            verify_word(0, xbar_pkg::PORT_GPU, word, xbar_pkg::port_e'(3'(n + 1)),
                        xbar_pkg::DIR_UP);
        end
    endtask

    task automatic arbitrate_fixed();
        clear_log();
        for (int i = 0; i < 5; i++) begin
            src_word[i] = next_word();
        end
        gpu_dst = xbar_pkg::PORT_SPINE3;
        load_all({4'd3, 2'd1});
        wait_done(5);
        verify_burst(1'b0);
    endtask

    task automatic arbitrate_round_robin();
        xbar_pkg::data_t word;
        @(posedge clk);
        arb_enable <= 1'b1;
        // One transfer moves the pointer off slot 0
        clear_log();
        word = next_word();
        put_gpu(word, {4'd4, 2'd0});
        wait_done(1);
        verify_word(0, xbar_pkg::PORT_SPINE4, word, xbar_pkg::PORT_GPU, xbar_pkg::DIR_DOWN);
        clear_log();
        for (int i = 0; i < 5; i++) begin
            src_word[i] = next_word();
        end
        gpu_dst = xbar_pkg::PORT_SPINE2;
        load_all({4'd2, 2'd3});
        wait_done(5);
        verify_burst(1'b1);
        @(posedge clk);
        arb_enable <= 1'b0;
    endtask

    task automatic stall_on_backpressure();
        xbar_pkg::data_t first;
        xbar_pkg::data_t second;
        clear_log();
        first  = next_word();
        second = next_word();
        @(posedge clk);
        spine_in_ready[2] <= 1'b0;
        put_gpu(first, {4'd2, 2'd2});
        put_gpu(second, {4'd2, 2'd1});
        do @(negedge clk); while (!spine_in_valid[2]);
        repeat (12) begin
            compare("spine2_in_valid held", 32'd1, 32'(spine_in_valid[2]));
            compare("spine2_in_data held", 32'(first), 32'(spine_in_data[2]));
            compare("busy while stalled", 32'd1, 32'(busy));
            compare("gpu_in_ready with slot full", 32'd0, 32'(gpu_in_ready));
            @(negedge clk);
        end
        @(posedge clk);
        spine_in_ready[2] <= 1'b1;
        wait_done(2);
        verify_word(0, xbar_pkg::PORT_SPINE2, first, xbar_pkg::PORT_GPU, xbar_pkg::DIR_DOWN);
        verify_word(1, xbar_pkg::PORT_SPINE2, second, xbar_pkg::PORT_GPU, xbar_pkg::DIR_DOWN);
    endtask

    // ====================
    // Watchdog
    // ====================
    initial begin
        #((NUM_TESTS * 200 + 10) * CLK_NS);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Test failed");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        arb_enable    <= 1'b0;
        gpu_in_data   <= '0;
        gpu_in_valid  <= 1'b0;
        gpu_dest_addr <= '0;
        gpu_out_ready <= 1'b1;
        for (int i = 1; i <= 4; i++) begin
            spine_out_data[i]  <= '0;
            spine_out_valid[i] <= 1'b0;
            spine_in_ready[i]  <= 1'b1;
        end
        @(negedge reset);
        reset_values();
        route_gpu_words();
        return_spine_words();
        arbitrate_round_robin();
        arbitrate_fixed();
        stall_on_backpressure();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int HALF_NS = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // Reset held for 10 cycles
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* spine_crossbar.sv */
`timescale 1ns/10ps
`default_nettype none

module spine_crossbar (
    input  logic              clk,
    input  logic              reset,
    input  logic              arb_enable,

    // GPU port
    input  xbar_pkg::data_t   gpu_in_data,
    input  logic              gpu_in_valid,
    output logic              gpu_in_ready,
    input  xbar_pkg::addr_t   gpu_dest_addr,
    output xbar_pkg::data_t   gpu_out_data,
    output logic              gpu_out_valid,
    input  logic              gpu_out_ready,

    // Spine ports
    input  xbar_pkg::data_t   spine1_out_data,
    input  logic              spine1_out_valid,
    output logic              spine1_out_ready,
    output xbar_pkg::data_t   spine1_in_data,
    output logic              spine1_in_valid,
    input  logic              spine1_in_ready,

    input  xbar_pkg::data_t   spine2_out_data,
    input  logic              spine2_out_valid,
    output logic              spine2_out_ready,
    output xbar_pkg::data_t   spine2_in_data,
    output logic              spine2_in_valid,
    input  logic              spine2_in_ready,

    input  xbar_pkg::data_t   spine3_out_data,
    input  logic              spine3_out_valid,
    output logic              spine3_out_ready,
    output xbar_pkg::data_t   spine3_in_data,
    output logic              spine3_in_valid,
    input  logic              spine3_in_ready,

    input  xbar_pkg::data_t   spine4_out_data,
    input  logic              spine4_out_valid,
    output logic              spine4_out_ready,
    output xbar_pkg::data_t   spine4_in_data,
    output logic              spine4_in_valid,
    input  logic              spine4_in_ready,

    // Status
    output logic              busy,
    output xbar_pkg::port_e   current_grant,
    output xbar_pkg::dir_e    direction
);

    xbar_pkg::data_t [3:0] spine_out_data;
    logic [3:0]            spine_out_valid;
    logic [3:0]            spine_out_ready;
    xbar_pkg::data_t [3:0] spine_in_data;
    logic [3:0]            spine_in_valid;
    logic [3:0]            spine_in_ready;
    logic [2:0]            ptr;
    logic                  step;

    // Spine 1 sits at vector index 0
    assign spine_out_data  = {spine4_out_data, spine3_out_data,
                              spine2_out_data, spine1_out_data};
    assign spine_out_valid = {spine4_out_valid, spine3_out_valid,
                              spine2_out_valid, spine1_out_valid};
    assign spine_in_ready  = {spine4_in_ready, spine3_in_ready,
                              spine2_in_ready, spine1_in_ready};

    assign {spine4_out_ready, spine3_out_ready,
            spine2_out_ready, spine1_out_ready} = spine_out_ready;
    assign {spine4_in_data, spine3_in_data,
            spine2_in_data, spine1_in_data}     = spine_in_data;
    assign {spine4_in_valid, spine3_in_valid,
            spine2_in_valid, spine1_in_valid}   = spine_in_valid;

    xbar_req_if    u_req_if ();
    xbar_egress_if u_egr_if ();

    ingress_slots u_ingress_slots (
        .clk             (clk),
        .reset           (reset),
        .gpu_in_data     (gpu_in_data),
        .gpu_in_valid    (gpu_in_valid),
        .gpu_dest_addr   (gpu_dest_addr),
        .gpu_in_ready    (gpu_in_ready),
        .spine_out_data  (spine_out_data),
        .spine_out_valid (spine_out_valid),
        .spine_out_ready (spine_out_ready),
        .req             (u_req_if)
    );

    rr_pointer u_rr_pointer (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .ptr   (ptr)
    );

    crossbar_fsm u_crossbar_fsm (
        .clk           (clk),
        .reset         (reset),
        .arb_enable    (arb_enable),
        .req           (u_req_if),
        .egr           (u_egr_if),
        .ptr           (ptr),
        .step          (step),
        .busy          (busy),
        .current_grant (current_grant),
        .direction     (direction)
    );

    egress_stage u_egress_stage (
        .clk            (clk),
        .reset          (reset),
        .req            (u_req_if),
        .egr            (u_egr_if),
        .gpu_out_data   (gpu_out_data),
        .gpu_out_valid  (gpu_out_valid),
        .gpu_out_ready  (gpu_out_ready),
        .spine_in_data  (spine_in_data),
        .spine_in_valid (spine_in_valid),
        .spine_in_ready (spine_in_ready)
    );

endmodule

`default_nettype wire

/* egress_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module egress_stage (
    input  logic                  clk,
    input  logic                  reset,

    xbar_req_if.datapath          req,
    xbar_egress_if.datapath       egr,

    output xbar_pkg::data_t       gpu_out_data,
    output logic                  gpu_out_valid,
    input  logic                  gpu_out_ready,

    output xbar_pkg::data_t [3:0] spine_in_data,
    output logic [3:0]            spine_in_valid,
    input  logic [3:0]            spine_in_ready
);

    xbar_pkg::data_t                           src_word;
    xbar_pkg::data_t                           xfer_data;
    logic                                      load_d;
    logic [xbar_pkg::NUM_PORTS-1:0]            dst_hot;
    logic [xbar_pkg::NUM_PORTS-1:0]            out_ready;
    logic [xbar_pkg::NUM_PORTS-1:0]            out_valid_q;
    xbar_pkg::data_t [xbar_pkg::NUM_PORTS-1:0] out_data_q;

    assign out_ready = {spine_in_ready, gpu_out_ready};

    // Source mux and destination decode
    always_comb begin
        src_word = '0;
        dst_hot  = '0;
        for (int i = 0; i < xbar_pkg::NUM_PORTS; i++) begin
            if (egr.src == xbar_pkg::port_e'(3'(i + 1))) begin
                src_word = req.payload[i];
            end
            dst_hot[i] = (egr.dst == xbar_pkg::port_e'(3'(i + 1)));
        end
    end

    // ====================
    // Output handshakes
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_d      <= 1'b0;
            out_valid_q <= '0;
        end else begin
            load_d <= egr.load;
            for (int i = 0; i < xbar_pkg::NUM_PORTS; i++) begin
                if (load_d && dst_hot[i]) begin
                    out_valid_q[i] <= 1'b1;
                end else if (out_ready[i]) begin
                    out_valid_q[i] <= 1'b0;
                end
            end
        end
    end

    // Data held stable until the port accepts it
    always_ff @(posedge clk) begin
        if (egr.load) begin
            xfer_data <= src_word;
        end
        for (int i = 0; i < xbar_pkg::NUM_PORTS; i++) begin
            if (load_d && dst_hot[i]) begin
                out_data_q[i] <= xfer_data;
            end
        end
    end

    assign egr.done = |(out_valid_q & out_ready & dst_hot);

    assign gpu_out_data   = out_data_q[0];
    assign gpu_out_valid  = out_valid_q[0];
    assign spine_in_data  = out_data_q[4:1];
    assign spine_in_valid = out_valid_q[4:1];

endmodule

`default_nettype wire

/* crossbar_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module crossbar_fsm (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 arb_enable,

    xbar_req_if.arbiter          req,
    xbar_egress_if.sequencer     egr,

    input  logic [2:0]           ptr,
    output logic                 step,

    output logic                 busy,
    output xbar_pkg::port_e      current_grant,
    output xbar_pkg::dir_e       direction
);

    xbar_pkg::xbar_state_e state_q;
    xbar_pkg::xbar_state_e state_d;
    xbar_pkg::port_e       src_q;
    xbar_pkg::port_e       dst_q;
    xbar_pkg::port_e       sel_src;
    xbar_pkg::port_e       sel_dst;
    logic [2:0]            start;
    logic [3:0]            idx;
    logic [2:0]            sel_idx;
    logic                  found;
    logic                  grant;

    // ====================
    // Arbitration
    // ====================
    // Fixed priority is a search that always starts at slot 0
    always_comb begin
        found   = 1'b0;
        sel_idx = 3'd0;
        start   = arb_enable ? ptr : 3'd0;
        for (int k = 0; k < xbar_pkg::NUM_PORTS; k++) begin
            idx = {1'b0, start} + 4'(k);
            if (idx >= 4'(xbar_pkg::NUM_PORTS)) begin
                idx = idx - 4'(xbar_pkg::NUM_PORTS);
            end
            if (!found && req.pending[idx[2:0]]) begin
                found   = 1'b1;
                sel_idx = idx[2:0];
            end
        end
    end

    assign grant   = (state_q == xbar_pkg::ST_IDLE) && found;
    assign sel_src = xbar_pkg::port_e'(sel_idx + 3'd1);
    assign sel_dst = (sel_idx == 3'd0) ? xbar_pkg::dest_to_port(req.gpu_dest)
                                       : xbar_pkg::PORT_GPU;

    assign req.take = grant ? (5'd1 << sel_idx) : '0;

    // ====================
    // Sequencing
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            xbar_pkg::ST_IDLE: begin
                if (found) begin
                    state_d = xbar_pkg::ST_LOAD;
                end
            end
            xbar_pkg::ST_LOAD: state_d = xbar_pkg::ST_SEND;
            xbar_pkg::ST_SEND: begin
                if (egr.done) begin
                    state_d = xbar_pkg::ST_IDLE;
                end
            end
            default: state_d = xbar_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= xbar_pkg::ST_IDLE;
            src_q   <= xbar_pkg::PORT_NONE;
            dst_q   <= xbar_pkg::PORT_NONE;
        end else begin
            state_q <= state_d;
            if (grant) begin
                src_q <= sel_src;
                dst_q <= sel_dst;
            end
        end
    end

    assign egr.load = (state_q == xbar_pkg::ST_LOAD);
    assign egr.src  = src_q;
    assign egr.dst  = dst_q;

    // Pointer moves once per finished transfer
    assign step = (state_q == xbar_pkg::ST_SEND) && egr.done && arb_enable;

    // Status
    assign busy          = (state_q != xbar_pkg::ST_IDLE);
    assign current_grant = src_q;
    assign direction     = !busy ? xbar_pkg::DIR_NONE :
                           (src_q == xbar_pkg::PORT_GPU) ? xbar_pkg::DIR_DOWN
                                                         : xbar_pkg::DIR_UP;

endmodule

`default_nettype wire

/* rr_pointer.sv */
`timescale 1ns/10ps
`default_nettype none

module rr_pointer (
    input  logic       clk,
    input  logic       reset,
    input  logic       step,
    output logic [2:0] ptr
);

    logic [2:0] ptr_q;

    // Start slot for the next round-robin search
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr_q <= 3'd0;
        end else if (step) begin
            if (ptr_q == 3'(xbar_pkg::NUM_PORTS - 1)) begin
                ptr_q <= 3'd0;
            end else begin
                ptr_q <= ptr_q + 3'd1;
            end
        end
    end

    assign ptr = ptr_q;

endmodule

`default_nettype wire

/* ingress_slots.sv */
`timescale 1ns/10ps
`default_nettype none

module ingress_slots (
    input  logic                  clk,
    input  logic                  reset,

    input  xbar_pkg::data_t       gpu_in_data,
    input  logic                  gpu_in_valid,
    input  xbar_pkg::addr_t       gpu_dest_addr,
    output logic                  gpu_in_ready,

    input  xbar_pkg::data_t [3:0] spine_out_data,
    input  logic [3:0]            spine_out_valid,
    output logic [3:0]            spine_out_ready,

    xbar_req_if.slots             req
);

    logic [xbar_pkg::NUM_PORTS-1:0]            in_valid;
    xbar_pkg::data_t [xbar_pkg::NUM_PORTS-1:0] in_data;
    logic [xbar_pkg::NUM_PORTS-1:0]            pending_q;
    logic [xbar_pkg::NUM_PORTS-1:0]            accept;
    xbar_pkg::data_t [xbar_pkg::NUM_PORTS-1:0] data_q;
    xbar_pkg::addr_t                           gpu_dest_q;

    assign in_valid = {spine_out_valid, gpu_in_valid};
    assign in_data  = {spine_out_data, gpu_in_data};

    // Ready while the slot is empty
    assign gpu_in_ready    = ~pending_q[0];
    assign spine_out_ready = ~pending_q[4:1];
    assign accept          = in_valid & ~pending_q;

    // ====================
    // Slot occupancy
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending_q <= '0;
        end else begin
            for (int i = 0; i < xbar_pkg::NUM_PORTS; i++) begin
                if (req.take[i]) begin
                    pending_q[i] <= 1'b0;
                end else if (accept[i]) begin
                    pending_q[i] <= 1'b1;
                end
            end
        end
    end

    // Slot contents
    always_ff @(posedge clk) begin
        for (int i = 0; i < xbar_pkg::NUM_PORTS; i++) begin
            if (accept[i]) begin
                data_q[i] <= in_data[i];
            end
        end
        if (accept[0]) begin
            gpu_dest_q <= gpu_dest_addr;
        end
    end

    assign req.pending  = pending_q;
    assign req.payload  = data_q;
    assign req.gpu_dest = gpu_dest_q;

endmodule

`default_nettype wire

/* xbar_egress_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface xbar_egress_if;

    logic            load;
    xbar_pkg::port_e src;
    xbar_pkg::port_e dst;
    logic            done;

    modport sequencer (
        output load,
        output src,
        output dst,
        input  done
    );

    modport datapath (
        input  load,
        input  src,
        input  dst,
        output done
    );

endinterface

`default_nettype wire

/* xbar_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface xbar_req_if;

    // Slot 0 is the GPU and slots 1 to 4 are the spines
    logic [xbar_pkg::NUM_PORTS-1:0]                 pending;
    xbar_pkg::data_t [xbar_pkg::NUM_PORTS-1:0]      payload;
    xbar_pkg::addr_t                                gpu_dest;
    logic [xbar_pkg::NUM_PORTS-1:0]                 take;

    modport slots (
        output pending,
        output payload,
        output gpu_dest,
        input  take
    );

    modport arbiter (
        input  pending,
        input  gpu_dest,
        output take
    );

    modport datapath (
        input  payload
    );

endinterface

`default_nettype wire

/* xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

    localparam int DATA_W        = 16;
    localparam int ADDR_W        = 6;
    localparam int NUM_PORTS     = 5;
    localparam int SPINE_SEL_LSB = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Port code doubles as current_grant and is the slot index plus one
    typedef enum logic [2:0] {
        PORT_NONE   = 3'd0,
        PORT_GPU    = 3'd1,
        PORT_SPINE1 = 3'd2,
        PORT_SPINE2 = 3'd3,
        PORT_SPINE3 = 3'd4,
        PORT_SPINE4 = 3'd5
    } port_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_SEND = 2'd2
    } xbar_state_e;

    typedef enum logic [1:0] {
        DIR_NONE = 2'd0,
        DIR_DOWN = 2'd1,
        DIR_UP   = 2'd2
    } dir_e;

    // Unknown spine select values fall back to spine 1
    function automatic port_e dest_to_port(addr_t addr);
        logic [ADDR_W-SPINE_SEL_LSB-1:0] sel;
        sel = addr[ADDR_W-1:SPINE_SEL_LSB];
        case (sel)
            'd1:     return PORT_SPINE1;
            'd2:     return PORT_SPINE2;
            'd3:     return PORT_SPINE3;
            'd4:     return PORT_SPINE4;
            default: return PORT_SPINE1;
        endcase
    endfunction

endpackage

`default_nettype wire
